// ==== tb.f ====
src/prio_pkg.sv
src/priority_scanner.sv
src/req_capture.sv
src/prio_arbiter_top.sv
dv/tb_clock.sv
dv/prio_arbiter_asserts.sv
dv/prio_arbiter_tb.sv

// ==== Makefile ====
# Verilator build and run for the priority arbiter testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := prio_arbiter_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/prio_arbiter_tb.sv ====
// Testbench top for the priority arbiter, runs random and directed requests against a model
`timescale 1ns/1ps

module prio_arbiter_tb;

    import prio_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_HOLD     = 7;
    localparam int ACK_BOUND    = 2 * NUM_REQ + 8;
    // Random, empty, full, walking ones and the back-pressure sequence
    localparam int NUM_TX       = NUM_RANDOM + 2 + NUM_REQ + 3;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 + NUM_TX * (ACK_BOUND + MAX_HOLD);

    logic               clk;
    logic               rst_n;
    logic               req;
    logic [NUM_REQ-1:0] req_vec;
    logic               ack;
    logic [IDX_W-1:0]   grant;
    logic               grant_valid;

    logic [31:0]        rand_state;
    logic [31:0]        rand_word;
    logic [NUM_REQ-1:0] stim_vec;
    int                 stim_hold;
    int                 fail_count;

    tb_clock u_clock (
        .clk (clk)
    );

    prio_arbiter_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_vec     (req_vec),
        .ack         (ack),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    // LCG, upper bits are the better ones
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Model: highest set line, zero and not found for an empty vector
    function automatic void highest_set(input logic [NUM_REQ-1:0] vec,
                                        output logic [IDX_W-1:0] index,
                                        output logic             any_set);
        index   = '0;
        any_set = 1'b0;
        for (int b = 0; b < NUM_REQ; b++) begin
            if (vec[b]) begin
                index   = IDX_W'(b);
                any_set = 1'b1;
            end
        end
    endfunction

    task automatic abort_run();
        fail_count++;
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input int got, input int expected);
        $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
        abort_run();
    endtask

    task automatic event_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        abort_run();
    endtask

    // Polls ack on falling edges until it reaches the wanted level
    task automatic wait_ack(input logic level, input string phase);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack !== level && cycles < ACK_BOUND);
        assert (ack === level)
            else event_error($sformatf("ack did not %s within %0d cycles", phase, ACK_BOUND));
    endtask

    // One full four-phase transaction, req held for extra cycles after ack
    task automatic run_request(input logic [NUM_REQ-1:0] vec, input int hold);
        logic [IDX_W-1:0] exp_idx;
        logic             exp_found;
        logic [31:0]      noise;
        highest_set(vec, exp_idx, exp_found);
        @(posedge clk);
        req     <= 1'b1;
        req_vec <= vec;
        wait_ack(1'b1, "rise");
        assert (grant == exp_idx)
            else value_error("grant", int'(grant), int'(exp_idx));
        assert (grant_valid == exp_found)
            else value_error("grant_valid", int'(grant_valid), int'(exp_found));
        for (int h = 0; h < hold; h++) begin
            // Lines may move once ack is up, the grant must not
            @(posedge clk);
            noise = next_rand();
            req_vec <= noise[31:24];
            @(negedge clk);
            assert (ack === 1'b1)
                else value_error("ack", int'(ack), 1);
            assert (grant == exp_idx)
                else value_error("grant", int'(grant), int'(exp_idx));
            assert (grant_valid == exp_found)
                else value_error("grant_valid", int'(grant_valid), int'(exp_found));
        end
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0, "fall");
    endtask

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        event_error($sformatf("timeout, run did not end within %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        rand_state = 32'hbcf4;
        fail_count = 0;
        rst_n      = 1'b0;
        req        = 1'b0;
        req_vec    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // Outputs idle after reset
        assert (ack === 1'b0) else value_error("ack", int'(ack), 0);
        assert (grant_valid === 1'b0) else value_error("grant_valid", int'(grant_valid), 0);
        assert (grant === '0) else value_error("grant", int'(grant), 0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rand_word = next_rand();
            stim_vec  = rand_word[31:24];
            rand_word = next_rand();
            stim_hold = int'(rand_word[30:28]);
            run_request(stim_vec, stim_hold);
        end

        // Empty and full vectors
        run_request('0, 0);
        run_request('1, 0);

        // Walking one
        for (int b = 0; b < NUM_REQ; b++) begin
            run_request(NUM_REQ'(1) << b, 0);
        end

        // Long hold on the top line, then requests that must not see it again
        run_request({1'b1, {(NUM_REQ - 1){1'b0}}}, MAX_HOLD);
        run_request('0, 3);
        run_request(NUM_REQ'(1), 0);

        if (fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// ==== dv/prio_arbiter_asserts.sv ====
// Concurrent handshake and scanner checks, bound onto the arbiter top level during simulation
`timescale 1ns/1ps

module prio_arbiter_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       req,
    input logic                       ack,
    input logic [prio_pkg::IDX_W-1:0] grant,
    input logic                       grant_valid,
    input logic [1:0]                 scan_state
);

    import prio_pkg::*;

    // ack may only rise in answer to a pending request
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // ack drops only once the requester has let go
    ack_fall_needs_req_low: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // Result frozen across the acknowledge phase
    grant_stable_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && $past(ack)) |-> ($stable(grant) && $stable(grant_valid)))
        else $error("grant or grant_valid changed while ack was high");

    // Grant only moves right after the scanner has passed through DONE
    grant_changes_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable({grant, grant_valid}) |-> ($past(scan_state) == SCAN_DONE))
        else $error("grant changed without a completed scan");

endmodule

bind prio_arbiter_top prio_arbiter_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .ack         (ack),
    .grant       (grant),
    .grant_valid (grant_valid),
    .scan_state  (u_priority_scanner.state)
);

// ==== dv/tb_clock.sv ====
// Free-running testbench clock, instantiated by the testbench top to drive the DUT
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 100 ns period
    localparam int HALF_PERIOD_NS = 50;

    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD_NS clk = ~clk;

endmodule

// ==== src/prio_arbiter_top.sv ====
// Top level of the priority arbiter, joining the handshake controller to the serial scanner
`timescale 1ns/1ps

module prio_arbiter_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req,
    input  logic [prio_pkg::NUM_REQ-1:0] req_vec,
    output logic                         ack,
    output logic [prio_pkg::IDX_W-1:0]   grant,
    output logic                         grant_valid
);

    import prio_pkg::*;

    // Controller to scanner
    logic               start;
    logic [NUM_REQ-1:0] scan_vec;

    // Scanner back to controller
    logic               done;
    logic [IDX_W-1:0]   idx;
    logic               found;

    // Handshake and result holding
    req_capture u_req_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_vec     (req_vec),
        .ack         (ack),
        .start       (start),
        .scan_vec    (scan_vec),
        .done        (done),
        .idx         (idx),
        .found       (found),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    // Bit-serial search, NUM_REQ + 1 cycles from start to done
    priority_scanner u_priority_scanner (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .scan_vec (scan_vec),
        .done     (done),
        .idx      (idx),
        .found    (found)
    );

endmodule

// ==== src/req_capture.sv ====
// Four-phase req/ack controller that freezes the request vector, starts a scan and holds the grant
`timescale 1ns/1ps

module req_capture (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req,
    input  logic [prio_pkg::NUM_REQ-1:0] req_vec,
    output logic                         ack,
    output logic                         start,
    output logic [prio_pkg::NUM_REQ-1:0] scan_vec,
    input  logic                         done,
    input  logic [prio_pkg::IDX_W-1:0]   idx,
    input  logic                         found,
    output logic [prio_pkg::IDX_W-1:0]   grant,
    output logic                         grant_valid
);

    import prio_pkg::*;

    // Handshake phases
    typedef enum logic [1:0] {
        CAP_IDLE      = 2'b00,
        CAP_WAIT_DONE = 2'b01,
        CAP_HOLD_ACK  = 2'b10
    } cap_state_t;

    cap_state_t cap_state;
    logic       accept;
    logic       release_ack;

    // New request taken only when idle with ack already low
    assign accept = (cap_state == CAP_IDLE) && req && !ack;

    // Requester has dropped req, finish the handshake
    assign release_ack = (cap_state == CAP_HOLD_ACK) && !req;

    // Control path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_state   <= CAP_IDLE;
            start       <= 1'b0;
            ack         <= 1'b0;
            grant       <= '0;
            grant_valid <= 1'b0;
        end else begin
            // Start is a single-cycle pulse
            start <= 1'b0;
            case (cap_state)
                CAP_IDLE: begin
                    if (accept) begin
                        start     <= 1'b1;
                        cap_state <= CAP_WAIT_DONE;
                    end
                end
                CAP_WAIT_DONE: begin
                    if (done) begin
                        // Result is frozen here for the whole ack phase
                        grant       <= idx;
                        grant_valid <= found;
                        ack         <= 1'b1;
                        cap_state   <= CAP_HOLD_ACK;
                    end
                end
                CAP_HOLD_ACK: begin
                    if (release_ack) begin
                        ack       <= 1'b0;
                        cap_state <= CAP_IDLE;
                    end
                end
                default: begin
                    cap_state <= CAP_IDLE;
                end
            endcase
        end
    end

    // Frozen copy of the request lines for the scanner
    always_ff @(posedge clk) begin
        if (accept) begin
            scan_vec <= req_vec;
        end
    end

endmodule

// ==== src/priority_scanner.sv ====
// Serial scanner that walks a captured request vector one bit per clock and reports the top set index
`timescale 1ns/1ps

module priority_scanner (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [prio_pkg::NUM_REQ-1:0] scan_vec,
    output logic                         done,
    output logic [prio_pkg::IDX_W-1:0]   idx,
    output logic                         found
);

    import prio_pkg::*;

    logic [1:0]       state;
    logic [1:0]       state_next;
    logic [IDX_W-1:0] bit_cnt;
    logic [IDX_W-1:0] work_idx;
    logic             work_found;
    logic [IDX_W-1:0] work_idx_next;
    logic             work_found_next;
    logic             bit_hit;
    logic             last_bit;
    logic             scan_begin;
    logic             scan_end;

    // Scan starts only from idle, ends on the last bit position
    assign scan_begin = (state == SCAN_IDLE) && start;
    assign last_bit   = (bit_cnt == IDX_W'(NUM_REQ - 1));
    assign scan_end   = (state == SCAN_RUN) && last_bit;

    // Current bit under the counter
    assign bit_hit = (state == SCAN_RUN) && scan_vec[bit_cnt];

    // Later set bits overwrite earlier ones, so the highest index wins
    assign work_idx_next   = bit_hit ? bit_cnt : work_idx;
    assign work_found_next = work_found | bit_hit;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            SCAN_IDLE: begin
                if (start) begin
                    state_next = SCAN_RUN;
                end
            end
            SCAN_RUN: begin
                if (last_bit) begin
                    state_next = SCAN_DONE;
                end
            end
            SCAN_DONE: begin
                state_next = SCAN_IDLE;
            end
            default: begin
                state_next = SCAN_IDLE;
            end
        endcase
    end

    // State register and bit counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SCAN_IDLE;
            bit_cnt <= '0;
        end else begin
            state <= state_next;
            if (scan_begin) begin
                bit_cnt <= '0;
            end else if (state == SCAN_RUN) begin
                // Wraps back to zero after the last bit
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Working result, cleared at the start of every scan
    always_ff @(posedge clk) begin
        if (scan_begin) begin
            work_idx   <= '0;
            work_found <= 1'b0;
        end else if (state == SCAN_RUN) begin
            work_idx   <= work_idx_next;
            work_found <= work_found_next;
        end
    end

    // Published result, touched only when the scan finishes
    // The last bit is folded in through the next-value terms
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx   <= '0;
            found <= 1'b0;
        end else if (scan_end) begin
            idx   <= work_idx_next;
            found <= work_found_next;
        end
    end

    // One-cycle pulse, the FSM never stays in DONE
    assign done = (state == SCAN_DONE);

endmodule

// ==== src/prio_pkg.sv ====
// Shared widths and scanner state encodings, imported by the arbiter RTL and its testbench
package prio_pkg;

    // Number of request lines presented per transaction
    localparam int NUM_REQ = 8;

    // Width of a request index, also used for the scan counter
    localparam int IDX_W = $clog2(NUM_REQ);

    // Scanner FSM encodings
    // IDLE waits for start, RUN walks the vector, DONE lasts one cycle
    localparam logic [1:0] SCAN_IDLE = 2'b00;
    localparam logic [1:0] SCAN_RUN  = 2'b01;
    localparam logic [1:0] SCAN_DONE = 2'b10;

    // 2'b11 is never entered by the scanner

endpackage
